// File: src/cache_config.svh
`ifndef CACHE_CONFIG_SVH
`define CACHE_CONFIG_SVH

// four-way, 16 sets, 32-byte lines
`define WAYS        4
`define SET_BITS    4
`define OFFSET_BITS 5

// address bits above set and offset
`define TAG_BITS    23

`define LINE_BITS   256

`endif

// File: src/cache_pkg.sv
`default_nettype none
`include "cache_config.svh"

package cache_pkg;

    typedef struct packed {
        logic [`TAG_BITS-1:0]    tag;
        logic [`SET_BITS-1:0]    set;
        logic [`OFFSET_BITS-1:0] offset;
    } addr_fields_t;

    // one word, read raw or split into fields
    typedef union packed {
        logic [31:0]  raw;
        addr_fields_t f;
    } cache_addr_u;

    typedef struct packed {
        cache_addr_u addr;
        logic [3:0]  rmask;
        logic [3:0]  wmask;
        logic [31:0] wdata;
    } stage_reg_t;

    typedef enum logic [1:0] {
        MISS_IDLE,
        MISS_WB,      // dirty victim out
        MISS_FILL,    // line in, written on resp
        MISS_INSTALL  // re-read of the new line
    } miss_state_t;

endpackage

`default_nettype wire

// File: src/cache_if.sv
`timescale 1ns/100ps
`default_nettype none
`include "cache_config.svh"

// per-way lookup results for the set in stage 2
interface array_rd_if;
    logic [`SET_BITS-1:0]  set;
    logic [`WAYS-1:0]      valid;
    logic [`WAYS-1:0]      dirty;
    logic [`TAG_BITS-1:0]  tag  [`WAYS];
    logic [`LINE_BITS-1:0] data [`WAYS];

    modport issue  (output set);
    modport array  (input set, output valid, dirty, tag, data);
    modport lookup (input valid, dirty, tag, data);
endinterface

// single-way write, byte strobed
interface array_wr_if;
    logic                    we;
    logic [1:0]              way;
    logic [`SET_BITS-1:0]    set;
    logic [`LINE_BITS/8-1:0] strobe;
    logic [`LINE_BITS-1:0]   data;
    logic [`TAG_BITS-1:0]    tag;
    logic                    valid;
    logic                    dirty;

    modport writer (
        output we, way, set, strobe, data, tag, valid, dirty
    );
    modport array (
        input we, way, set, strobe, data, tag, valid, dirty
    );
endinterface

`default_nettype wire

// File: src/way_arrays.sv
`timescale 1ns/100ps
`default_nettype none
`include "cache_config.svh"

module way_arrays (
    input  logic       clk,
    input  logic       rst,
    array_rd_if.array  rd,
    array_wr_if.array  wr
);

    localparam int SETS  = 1 << `SET_BITS;
    localparam int BYTES = `LINE_BITS / 8;

    logic [SETS-1:0]       valid_mem [`WAYS];
    logic [SETS-1:0]       dirty_mem [`WAYS];
    logic [`TAG_BITS-1:0]  tag_mem   [`WAYS][SETS];
    logic [`LINE_BITS-1:0] data_mem  [`WAYS][SETS];

    // line state bits
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int w = 0; w < `WAYS; w++) begin
                valid_mem[w] <= '0;
                dirty_mem[w] <= '0;
            end
        end else if (wr.we) begin
            valid_mem[wr.way][wr.set] <= wr.valid;
            dirty_mem[wr.way][wr.set] <= wr.dirty;
        end
    end

    always_ff @(posedge clk) begin
        if (wr.we) begin
            tag_mem[wr.way][wr.set] <= wr.tag;
            for (int b = 0; b < BYTES; b++) begin
                if (wr.strobe[b]) begin
                    data_mem[wr.way][wr.set][b*8 +: 8] <= wr.data[b*8 +: 8];
                end
            end
        end
    end

    // all ways read every cycle, old data on a same-edge write
    always_ff @(posedge clk) begin
        for (int w = 0; w < `WAYS; w++) begin
            rd.valid[w] <= valid_mem[w][rd.set];
            rd.dirty[w] <= dirty_mem[w][rd.set];
            rd.tag[w]   <= tag_mem[w][rd.set];
            rd.data[w]  <= data_mem[w][rd.set];
        end
    end

    a_write_way_known: assert property (
        @(posedge clk) disable iff (rst)
        wr.we |-> !$isunknown(wr.way) && !$isunknown(wr.set)
    ) else $error("way_arrays: write way/set unknown way=%h set=%h", wr.way, wr.set);

endmodule

`default_nettype wire

// File: src/plru_tree.sv
`timescale 1ns/100ps
`default_nettype none
`include "cache_config.svh"

module plru_tree (
    input  logic                 clk,
    input  logic                 rst,
    input  logic [`SET_BITS-1:0] set,
    input  logic                 update,
    input  logic [1:0]           hit_way,
    output logic [1:0]           victim_way
);

    localparam int SETS = 1 << `SET_BITS;

    // bit 0 root, bit 1 leaf of ways 0/1, bit 2 leaf of ways 2/3
    logic [2:0] tree [SETS];
    logic [2:0] cur;

    assign cur        = tree[set];
    assign victim_way = cur[0] ? {1'b1, cur[2]} : {1'b0, cur[1]};

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < SETS; s++) begin
                tree[s] <= 3'b000;
            end
        end else if (update) begin
            tree[set][0] <= ~hit_way[1];       // root away from hit half
            if (hit_way[1]) begin
                tree[set][2] <= ~hit_way[0];
            end else begin
                tree[set][1] <= ~hit_way[0];
            end
        end
    end

endmodule

`default_nettype wire

// File: src/cache_stage1.sv
`timescale 1ns/100ps
`default_nettype none

module cache_stage1 (
    input  logic                  clk,
    input  logic                  rst,
    input  logic [31:0]           ufp_addr,
    input  logic [3:0]            ufp_rmask,
    input  logic [3:0]            ufp_wmask,
    input  logic [31:0]           ufp_wdata,
    input  logic                  halt,
    input  logic                  replay,
    output logic                  ufp_ready,
    output cache_pkg::stage_reg_t stage_reg,
    output logic                  stage_live,
    array_rd_if.issue             rd
);

    cache_pkg::cache_addr_u in_addr;
    logic                   ready_q;
    logic                   hold;
    logic                   request;

    assign in_addr.raw = ufp_addr;
    assign hold        = halt | replay;
    assign request     = (ufp_rmask != 4'b0) || (ufp_wmask != 4'b0);
    assign ufp_ready   = ready_q & ~hold;

    // held set re-reads the arrays while stage 2 works on it
    assign rd.set = hold ? stage_reg.addr.f.set : in_addr.f.set;

    always_ff @(posedge clk) begin
        if (rst) begin
            ready_q    <= 1'b0;
            stage_live <= 1'b0;
        end else begin
            ready_q <= 1'b1;
            if (ufp_ready) begin
                stage_live <= request;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ufp_ready) begin
            stage_reg.addr  <= in_addr;
            stage_reg.rmask <= ufp_rmask;
            stage_reg.wmask <= ufp_wmask;
            stage_reg.wdata <= ufp_wdata;
        end
    end

    // stage 2 only holds a live request
    a_hold_keeps_request: assert property (
        @(posedge clk) disable iff (rst)
        (halt || replay) |-> stage_live
    ) else $error("cache_stage1: hold without a live request addr=%h",
                  stage_reg.addr.raw);

endmodule

`default_nettype wire

// File: src/cache_stage2.sv
`timescale 1ns/100ps
`default_nettype none
`include "cache_config.svh"

module cache_stage2 (
    input  logic                  clk,
    input  logic                  rst,
    input  cache_pkg::stage_reg_t stage_reg,
    input  logic                  stage_live,
    input  logic [1:0]            victim_way,
    input  logic [`LINE_BITS-1:0] dfp_rdata,
    input  logic                  dfp_resp,
    output logic                  halt,
    output logic                  replay,
    output logic [`SET_BITS-1:0]  set,
    output logic                  update,
    output logic [1:0]            hit_way,
    output logic                  ufp_resp,
    output logic [31:0]           ufp_rdata,
    output logic [31:0]           dfp_addr,
    output logic                  dfp_read,
    output logic                  dfp_write,
    output logic [`LINE_BITS-1:0] dfp_wdata,
    array_rd_if.lookup            rd,
    array_wr_if.writer            wr
);

    cache_pkg::miss_state_t    state;
    cache_pkg::miss_state_t    state_next;
    cache_pkg::cache_addr_u    wb_addr;
    logic                      done_q;
    logic                      active;
    logic                      hit;
    logic [1:0]                hit_idx;
    logic [`LINE_BITS-1:0]     hit_line;
    logic [`OFFSET_BITS-3:0]   word_idx;
    logic [31:0]               rmask_ext;
    logic [`LINE_BITS/8-1:0]   store_strobe;
    logic                      is_store;
    logic                      store_hit;
    logic                      miss;
    logic                      victim_dirty;

    // done_q marks the cycle after a store write
    assign active    = stage_live && !done_q && state == cache_pkg::MISS_IDLE;
    assign is_store  = stage_reg.wmask != 4'b0;
    assign word_idx  = stage_reg.addr.f.offset[`OFFSET_BITS-1:2];
    assign store_hit = active && hit && is_store;
    assign miss      = active && !hit;

    assign victim_dirty = rd.valid[victim_way] && rd.dirty[victim_way];

    always_comb begin
        hit      = 1'b0;
        hit_idx  = 2'b00;
        hit_line = rd.data[0];
        for (int w = 0; w < `WAYS; w++) begin
            if (rd.valid[w] && rd.tag[w] == stage_reg.addr.f.tag) begin
                hit      = 1'b1;
                hit_idx  = 2'(w);
                hit_line = rd.data[w];
            end
        end
    end

    always_comb begin
        store_strobe = '0;
        store_strobe[word_idx*4 +: 4] = stage_reg.wmask;
        for (int b = 0; b < 4; b++) begin
            rmask_ext[b*8 +: 8] = {8{stage_reg.rmask[b]}};
        end
    end

    assign ufp_rdata = hit_line[word_idx*32 +: 32] & rmask_ext;
    assign ufp_resp  = stage_live && (done_q || (active && hit && !is_store));

    assign set     = stage_reg.addr.f.set;
    assign update  = active && hit;
    assign hit_way = hit_idx;

    assign halt   = miss || state == cache_pkg::MISS_WB || state == cache_pkg::MISS_FILL;
    assign replay = store_hit || state == cache_pkg::MISS_INSTALL;

    // victim line address
    always_comb begin
        wb_addr.f.tag    = rd.tag[victim_way];
        wb_addr.f.set    = stage_reg.addr.f.set;
        wb_addr.f.offset = '0;
    end

    assign dfp_write = state == cache_pkg::MISS_WB;
    assign dfp_read  = state == cache_pkg::MISS_FILL;
    assign dfp_wdata = rd.data[victim_way];
    assign dfp_addr  = dfp_write ? wb_addr.raw
                                 : {stage_reg.addr.raw[31:`OFFSET_BITS], {`OFFSET_BITS{1'b0}}};

    always_comb begin
        wr.we     = 1'b0;
        wr.way    = hit_idx;
        wr.set    = stage_reg.addr.f.set;
        wr.strobe = store_strobe;
        wr.data   = {(`LINE_BITS/32){stage_reg.wdata}};
        wr.tag    = stage_reg.addr.f.tag;
        wr.valid  = 1'b1;
        wr.dirty  = 1'b1;
        if (store_hit) begin
            wr.we = 1'b1;
        end else if (state == cache_pkg::MISS_FILL && dfp_resp) begin
            wr.we     = 1'b1;                  // install clean
            wr.way    = victim_way;
            wr.strobe = '1;
            wr.data   = dfp_rdata;
            wr.dirty  = 1'b0;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            cache_pkg::MISS_IDLE: begin
                if (miss) begin
                    state_next = victim_dirty ? cache_pkg::MISS_WB : cache_pkg::MISS_FILL;
                end
            end
            cache_pkg::MISS_WB: begin
                if (dfp_resp) begin
                    state_next = cache_pkg::MISS_FILL;
                end
            end
            cache_pkg::MISS_FILL: begin
                if (dfp_resp) begin
                    state_next = cache_pkg::MISS_INSTALL;
                end
            end
            default: state_next = cache_pkg::MISS_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state  <= cache_pkg::MISS_IDLE;
            done_q <= 1'b0;
        end else begin
            state  <= state_next;
            done_q <= store_hit;
        end
    end

    // memory address stays put until the response
    a_dfp_held: assert property (
        @(posedge clk) disable iff (rst)
        (dfp_read || dfp_write) && !dfp_resp |=> $stable(dfp_addr)
    ) else $error("cache_stage2: dfp_addr moved before dfp_resp dfp_addr=%h", dfp_addr);

    // responses come only from a way holding the line
    a_resp_hit: assert property (
        @(posedge clk) disable iff (rst)
        ufp_resp |-> hit
    ) else $error("cache_stage2: ufp_resp without tag match addr=%h",
                  stage_reg.addr.raw);

endmodule

`default_nettype wire

// File: src/pipelined_cache.sv
`timescale 1ns/100ps
`default_nettype none
`include "cache_config.svh"

module pipelined_cache (
    input  logic                  clk,
    input  logic                  rst,
    input  logic [31:0]           ufp_addr,
    input  logic [3:0]            ufp_rmask,
    input  logic [3:0]            ufp_wmask,
    input  logic [31:0]           ufp_wdata,
    output logic                  ufp_ready,
    output logic                  ufp_resp,
    output logic [31:0]           ufp_rdata,
    output logic [31:0]           dfp_addr,
    output logic                  dfp_read,
    output logic                  dfp_write,
    output logic [`LINE_BITS-1:0] dfp_wdata,
    input  logic [`LINE_BITS-1:0] dfp_rdata,
    input  logic                  dfp_resp
);

    cache_pkg::stage_reg_t stage_reg;
    logic                  stage_live;
    logic                  halt;
    logic                  replay;
    logic [`SET_BITS-1:0]  plru_set;
    logic                  plru_update;
    logic [1:0]            hit_way;
    logic [1:0]            victim_way;

    array_rd_if rd_bus ();
    array_wr_if wr_bus ();

    cache_stage1 u_stage1 (
        .clk        (clk),
        .rst        (rst),
        .ufp_addr   (ufp_addr),
        .ufp_rmask  (ufp_rmask),
        .ufp_wmask  (ufp_wmask),
        .ufp_wdata  (ufp_wdata),
        .halt       (halt),
        .replay     (replay),
        .ufp_ready  (ufp_ready),
        .stage_reg  (stage_reg),
        .stage_live (stage_live),
        .rd         (rd_bus.issue)
    );

    way_arrays u_arrays (
        .clk (clk),
        .rst (rst),
        .rd  (rd_bus.array),
        .wr  (wr_bus.array)
    );

    plru_tree u_plru (
        .clk        (clk),
        .rst        (rst),
        .set        (plru_set),
        .update     (plru_update),
        .hit_way    (hit_way),
        .victim_way (victim_way)
    );

    cache_stage2 u_stage2 (
        .clk        (clk),
        .rst        (rst),
        .stage_reg  (stage_reg),
        .stage_live (stage_live),
        .victim_way (victim_way),
        .dfp_rdata  (dfp_rdata),
        .dfp_resp   (dfp_resp),
        .halt       (halt),
        .replay     (replay),
        .set        (plru_set),
        .update     (plru_update),
        .hit_way    (hit_way),
        .ufp_resp   (ufp_resp),
        .ufp_rdata  (ufp_rdata),
        .dfp_addr   (dfp_addr),
        .dfp_read   (dfp_read),
        .dfp_write  (dfp_write),
        .dfp_wdata  (dfp_wdata),
        .rd         (rd_bus.lookup),
        .wr         (wr_bus.writer)
    );

endmodule

`default_nettype wire

// File: test/line_memory.sv
`timescale 1ns/100ps
`default_nettype none
`include "cache_config.svh"

module line_memory (
    input  logic                  clk,
    input  logic                  rst,
    input  logic [31:0]           addr,
    input  logic                  read,
    input  logic                  write,
    input  logic [`LINE_BITS-1:0] wdata,
    output logic [`LINE_BITS-1:0] rdata,
    output logic                  resp
);

    localparam int LINES = 512;    // 16 KiB window

    logic [`LINE_BITS-1:0] lines [LINES];
    logic [31:0]           byte_addr;
    integer                seed;
    int                    delay;

    initial begin
        seed  = 32'hb0298336;
        resp  = 1'b0;
        rdata = '0;
        for (int l = 0; l < LINES; l++) begin
            for (int w = 0; w < 8; w++) begin
                byte_addr = 32'(l * 32 + w * 4);
                lines[l][w*32 +: 32] = (byte_addr * 32'h9e37_79b1) ^ 32'h5a5a_c3c3;
            end
        end
        forever begin
            @(posedge clk);
            #1;
            if (!rst && (read || write)) begin
                delay = 1 + (($random(seed) & 32'h7fff_ffff) % 6);   // 1 to 6 cycles
                repeat (delay - 1) begin
                    @(posedge clk);
                    #1;
                end
                if (write) begin
                    lines[addr[13:5]] = wdata;
                end else begin
                    rdata = lines[addr[13:5]];
                end
                resp = 1'b1;
                @(posedge clk);
                #1;
                resp = 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// File: test/tb_pipelined_cache.sv
`timescale 1ns/100ps
`default_nettype none
`include "cache_config.svh"

module tb_pipelined_cache;

    localparam int MISS_CYCLES = 20;   // write-back plus fill at the longest delay
    localparam int TIMEOUT     = 2 * (3 + 4 + 6 + 12 + 8) * MISS_CYCLES;

    logic                  clk;
    logic                  rst;
    logic [31:0]           ufp_addr;
    logic [3:0]            ufp_rmask;
    logic [3:0]            ufp_wmask;
    logic [31:0]           ufp_wdata;
    logic                  ufp_ready;
    logic                  ufp_resp;
    logic [31:0]           ufp_rdata;
    logic [31:0]           dfp_addr;
    logic                  dfp_read;
    logic                  dfp_write;
    logic [`LINE_BITS-1:0] dfp_wdata;
    logic [`LINE_BITS-1:0] dfp_rdata;
    logic                  dfp_resp;

    logic [`LINE_BITS-1:0] ref_lines  [512];
    logic                  line_dirty [512];
    logic [31:0]           exp_rdata  [64];
    logic                  exp_miss   [64];
    logic                  exp_wb     [64];
    logic                  read_seen;
    logic                  wb_seen;
    logic                  next_miss;
    logic                  next_wb;
    logic                  quiet_phase;
    logic                  burst_drive;
    int                    req_idx;
    int                    resp_idx;
    int                    errors;
    int                    errs_at;
    int                    tests;
    int                    failed_tests;
    int                    cycles = 0;
    int                    t;

    pipelined_cache DUT (.*);

    line_memory u_mem (
        .clk   (clk),
        .rst   (rst),
        .addr  (dfp_addr),
        .read  (dfp_read),
        .write (dfp_write),
        .wdata (dfp_wdata),
        .rdata (dfp_rdata),
        .resp  (dfp_resp)
    );

    initial clk = 1'b0;
    always #4 clk = ~clk;

    function automatic logic [31:0] addr_of(input int tag, input int set, input int word);
        return 32'((tag << 9) | (set << 5) | (word << 2));
    endfunction

    function automatic logic [31:0] mask_bytes(input logic [3:0] m);
        return {{8{m[3]}}, {8{m[2]}}, {8{m[1]}}, {8{m[0]}}};
    endfunction

    // reference memory and expected responses, updated at each accepting edge
    always @(posedge clk) begin
        if (rst) begin
            for (int l = 0; l < 512; l++) begin
                ref_lines[l]  <= u_mem.lines[l];
                line_dirty[l] <= 1'b0;
            end
            req_idx   <= 0;
            resp_idx  <= 0;
            read_seen <= 1'b0;
            wb_seen   <= 1'b0;
        end else begin
            if (ufp_ready && (ufp_rmask != 4'b0 || ufp_wmask != 4'b0)) begin
                exp_rdata[req_idx] <= ref_lines[ufp_addr[13:5]][ufp_addr[4:2]*32 +: 32]
                                      & mask_bytes(ufp_rmask);
                exp_miss[req_idx]  <= next_miss;
                exp_wb[req_idx]    <= next_wb;
                req_idx            <= req_idx + 1;
                for (int b = 0; b < 4; b++) begin
                    if (ufp_wmask[b]) begin
                        ref_lines[ufp_addr[13:5]][ufp_addr[4:2]*32 + b*8 +: 8]
                            <= ufp_wdata[b*8 +: 8];
                    end
                end
                if (ufp_wmask != 4'b0) begin
                    line_dirty[ufp_addr[13:5]] <= 1'b1;
                end
            end
            if (ufp_resp) begin
                resp_idx  <= resp_idx + 1;
                read_seen <= 1'b0;
                wb_seen   <= 1'b0;
            end
            if (dfp_read && dfp_resp) begin
                read_seen <= 1'b1;
            end
            if (dfp_write && dfp_resp) begin
                wb_seen                    <= 1'b1;
                line_dirty[dfp_addr[13:5]] <= 1'b0;
            end
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == TIMEOUT) begin
            $display("timeout after %0d cycles with %0d of %0d responses", cycles,
                     resp_idx, req_idx);
            $display("=== FAIL ===");
            $finish;
        end
    end

    a_ready_rise: assert property (@(posedge clk) $fell(rst) |-> !ufp_ready ##1 ufp_ready)
        else begin
            errors++;
            $display("ufp_ready did not rise one cycle after reset");
        end

    a_quiet: assert property (@(posedge clk) disable iff (rst)
        quiet_phase |-> !ufp_resp && !dfp_read && !dfp_write)
        else begin
            errors++;
            $display("error ufp_resp/dfp_read/dfp_write exp 0 got %h %h %h",
                     $sampled(ufp_resp), $sampled(dfp_read), $sampled(dfp_write));
        end

    a_rdata: assert property (@(posedge clk) disable iff (rst)
        ufp_resp |-> resp_idx < req_idx && ufp_rdata == exp_rdata[resp_idx])
        else begin
            errors++;
            $display("error ufp_rdata exp %h got %h",
                     exp_rdata[$sampled(resp_idx)], $sampled(ufp_rdata));
        end

    // fill and write-back traffic seen for each request
    a_traffic: assert property (@(posedge clk) disable iff (rst)
        ufp_resp |-> read_seen == exp_miss[resp_idx] && wb_seen == exp_wb[resp_idx])
        else begin
            errors++;
            $display("error dfp_read/dfp_write traffic exp %h/%h got %h/%h",
                     exp_miss[$sampled(resp_idx)], exp_wb[$sampled(resp_idx)],
                     $sampled(read_seen), $sampled(wb_seen));
        end

    a_wb_line: assert property (@(posedge clk) disable iff (rst)
        (dfp_write && dfp_resp) |-> line_dirty[dfp_addr[13:5]]
            && dfp_wdata == ref_lines[dfp_addr[13:5]])
        else begin
            errors++;
            $display("error dfp_wdata at dfp_addr %h exp %h got %h", $sampled(dfp_addr),
                     ref_lines[$sampled(dfp_addr[13:5])], $sampled(dfp_wdata));
        end

    a_dfp_addr: assert property (@(posedge clk) disable iff (rst)
        (dfp_read || dfp_write) |-> dfp_addr[31:14] == '0 && dfp_addr[4:0] == '0)
        else begin
            errors++;
            $display("error dfp_addr got %h", $sampled(dfp_addr));
        end

    a_burst: assert property (@(posedge clk) disable iff (rst)
        burst_drive |-> ufp_ready ##1 (ufp_resp && !dfp_read))
        else begin
            errors++;
            $display("load hit run stalled or dropped a response");
        end

    task automatic issue(input logic [31:0] a, input logic [3:0] rm, input logic [3:0] wm,
                         input logic [31:0] wd, input logic miss, input logic wb);
        next_miss = miss;
        next_wb   = wb;
        ufp_addr  = a;
        ufp_rmask = rm;
        ufp_wmask = wm;
        ufp_wdata = wd;
        @(negedge clk);
        while (!ufp_ready) begin
            @(negedge clk);
        end
        @(posedge clk);
        #1;
        ufp_rmask = 4'b0;    // idle unless the next issue follows at once
        ufp_wmask = 4'b0;
    endtask

    task automatic drain;
        while (resp_idx != req_idx) begin
            @(negedge clk);
        end
        @(posedge clk);
        #1;
    endtask

    task automatic report(input string name);
        tests++;
        if (errors != errs_at) begin
            failed_tests++;
        end
        $display("test %-15s %s", name, (errors == errs_at) ? "passed" : "failed");
        errs_at = errors;
    endtask

    initial begin
        rst          = 1'b1;
        ufp_addr     = '0;
        ufp_rmask    = 4'b0;
        ufp_wmask    = 4'b0;
        ufp_wdata    = '0;
        quiet_phase  = 1'b0;
        burst_drive  = 1'b0;
        next_miss    = 1'b0;
        next_wb      = 1'b0;
        errors       = 0;
        errs_at      = 0;
        tests        = 0;
        failed_tests = 0;
        repeat (10) @(posedge clk);
        #1;
        rst         = 1'b0;
        quiet_phase = 1'b1;
        repeat (6) @(posedge clk);
        #1;
        quiet_phase = 1'b0;
        report("reset");

        issue(addr_of(1, 0, 3), 4'hf, 4'h0, '0, 1'b1, 1'b0);
        issue(addr_of(1, 0, 3), 4'hf, 4'h0, '0, 1'b0, 1'b0);
        issue(addr_of(1, 0, 5), 4'b0110, 4'h0, '0, 1'b0, 1'b0);
        drain;
        report("cold_load");

        issue(addr_of(1, 0, 3), 4'h0, 4'b1010, 32'hdead_beef, 1'b0, 1'b0);
        issue(addr_of(1, 0, 3), 4'hf, 4'h0, '0, 1'b0, 1'b0);
        issue(addr_of(1, 0, 3), 4'h0, 4'b0001, 32'h1234_5677, 1'b0, 1'b0);
        issue(addr_of(1, 0, 3), 4'b1101, 4'h0, '0, 1'b0, 1'b0);
        drain;
        report("store_merge");

        // tags 2..5 land in ways 0, 2, 1, 3 and tag 6 evicts way 0
        for (t = 2; t < 6; t++) begin
            issue(addr_of(t, 3, t), 4'h0, 4'hf, 32'hc0de_0000 + t, 1'b1, 1'b0);
        end
        issue(addr_of(6, 3, 1), 4'h0, 4'b0011, 32'h0bad_f00d, 1'b1, 1'b1);
        issue(addr_of(2, 3, 2), 4'hf, 4'h0, '0, 1'b1, 1'b1);
        drain;
        report("write_back");

        for (t = 8; t < 12; t++) begin
            issue(addr_of(t, 5, 0), 4'hf, 4'h0, '0, 1'b1, 1'b0);
        end
        issue(addr_of(8, 5, 1), 4'hf, 4'h0, '0, 1'b0, 1'b0);
        issue(addr_of(9, 5, 2), 4'hf, 4'h0, '0, 1'b0, 1'b0);
        issue(addr_of(11, 5, 3), 4'hf, 4'h0, '0, 1'b0, 1'b0);
        issue(addr_of(12, 5, 4), 4'hf, 4'h0, '0, 1'b1, 1'b0);    // tag 10 leaves
        issue(addr_of(8, 5, 5), 4'hf, 4'h0, '0, 1'b0, 1'b0);
        issue(addr_of(9, 5, 6), 4'hf, 4'h0, '0, 1'b0, 1'b0);
        issue(addr_of(11, 5, 7), 4'hf, 4'h0, '0, 1'b0, 1'b0);
        issue(addr_of(10, 5, 0), 4'hf, 4'h0, '0, 1'b1, 1'b0);
        drain;
        report("replacement");

        burst_drive = 1'b1;
        for (t = 0; t < 8; t++) begin
            issue(addr_of(8 + t % 4, 5, t), 4'hf >> (t % 4), 4'h0, '0, 1'b0, 1'b0);
        end
        burst_drive = 1'b0;
        drain;
        report("pipelined_hits");

        $display("tests %0d, failed tests %0d, errors %0d", tests, failed_tests, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: pipelined_cache.f
+incdir+src
src/cache_pkg.sv
src/cache_if.sv
src/way_arrays.sv
src/plru_tree.sv
src/cache_stage1.sv
src/cache_stage2.sv
src/pipelined_cache.sv
test/line_memory.sv
test/tb_pipelined_cache.sv
